// File: include/proc_settings.svh
// Word width, register count and memory depths of the processor
`ifndef PROC_SETTINGS_SVH
`define PROC_SETTINGS_SVH

// Data and instruction word
`define PROC_WORD_W 16

// General registers
`define PROC_REG_COUNT 8

// Memory depths in words
`define PROC_IMEM_DEPTH 64
`define PROC_DMEM_DEPTH 64

`endif

// File: src/isaPkg.sv
// Word, register index and PC types, opcode encoding, instruction field positions
`default_nettype none
`include "proc_settings.svh"

package isaPkg;

    typedef logic [`PROC_WORD_W-1:0]              wordT;
    typedef logic [$clog2(`PROC_REG_COUNT)-1:0]  regIdxT;
    typedef logic [$clog2(`PROC_IMEM_DEPTH)-1:0] pcT;

    // Low two bits of the register-format opcodes pick the ALU operation
    typedef enum logic [4:0] {
        opNop  = 5'b00000,
        opHalt = 5'b00001,
        opAdd  = 5'b00100,
        opSub  = 5'b00101,
        opAnd  = 5'b00110,
        opXor  = 5'b00111,
        opAddi = 5'b01000,
        opLd   = 5'b01001,
        opSt   = 5'b01010,
        opBeqz = 5'b01100
    } opcodeT;

    // Field positions
    localparam int opcLsb = 11;
    localparam int rsLsb  = 8;
    localparam int rtLsb  = 5;
    localparam int rdLsb  = 2;
    localparam int immW   = 5;
    localparam int offW   = 8;

endpackage

`default_nettype wire

// File: src/pipePkg.sv
// ALU operation, forwarding selects and pipeline stage payload structs
`default_nettype none

package pipePkg;

    typedef enum logic [1:0] {
        aluAdd = 2'd0,
        aluSub = 2'd1,
        aluAnd = 2'd2,
        aluXor = 2'd3
    } aluOpT;

    // Operand source for execute
    localparam logic [1:0] fwdReg   = 2'd0;
    localparam logic [1:0] fwdExMem = 2'd1;
    localparam logic [1:0] fwdMemWb = 2'd2;

    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  isBranch;
        logic  isHalt;
        logic  illegal;
        logic  useImm;
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        isaPkg::wordT instr;
        isaPkg::pcT   pcNext;
    } ifIdT;

    typedef struct packed {
        ctrlT           ctrl;
        isaPkg::wordT   opA;
        isaPkg::wordT   opB;
        isaPkg::wordT   imm;
        isaPkg::pcT     brTarget;
        isaPkg::regIdxT rs;
        isaPkg::regIdxT rt;
        isaPkg::regIdxT rd;
        logic           usesRs;
        logic           usesRt;
    } idExT;

    typedef struct packed {
        ctrlT           ctrl;
        isaPkg::wordT   aluResult;
        isaPkg::wordT   storeData;
        isaPkg::regIdxT rd;
    } exMemT;

    typedef struct packed {
        isaPkg::wordT   wbData;
        isaPkg::regIdxT rd;
        logic           regWrite;
        logic           isHalt;
        logic           illegal;
    } memWbT;

endpackage

`default_nettype wire

// File: src/pipeStageIf.sv
// Pipeline register boundary interface with register, stage and control modports
`timescale 1ns/1ps
`default_nettype none

interface pipeStageIf #(
    parameter type payloadT = logic
);
    logic    valid;
    payloadT payload;
    logic    hold;
    logic    flush;

    modport regOut (output valid, output payload, input hold, input flush);
    modport stage (input valid, input payload);
    modport ctrl (output hold, output flush);
endinterface

`default_nettype wire

// File: src/pipeReg.sv
// Generic pipeline register with hold and flush
`timescale 1ns/1ps
`default_nettype none

module pipeReg #(
    parameter type payloadT = logic
) (
    input  wire logic    clk,
    input  wire logic    rstN,
    input  wire logic    validIn,
    input  wire payloadT dIn,
    pipeStageIf.regOut   outIf
);

    // Flush wins over hold
    always_ff @(posedge clk) begin
        if (!rstN) begin
            outIf.valid <= 1'b0;
        end else if (outIf.flush) begin
            outIf.valid <= 1'b0;
        end else if (!outIf.hold) begin
            outIf.valid <= validIn;
        end
    end

    always_ff @(posedge clk) begin
        if (!outIf.hold) begin
            outIf.payload <= dIn;
        end
    end

    validKnown: assert property (@(posedge clk) disable iff (!rstN)
        !$isunknown(outIf.valid))
        else $error("pipeline valid is unknown");

    // Hazard control must never ask for both on one boundary
    holdFlushExcl: assert property (@(posedge clk) disable iff (!rstN)
        !(outIf.hold && outIf.flush))
        else $error("hold and flush both high");

endmodule

`default_nettype wire

// File: src/fetchUnit.sv
// Program counter, instruction memory with load port and branch redirect
`timescale 1ns/1ps
`default_nettype none
`include "proc_settings.svh"

module fetchUnit (
    input  wire logic         clk,
    input  wire logic         rstN,
    input  wire logic         imemWe,
    input  wire isaPkg::pcT   imemAddr,
    input  wire isaPkg::wordT imemData,
    input  wire logic         pcHold,
    input  wire logic         redirect,
    input  wire isaPkg::pcT   redirectPc,
    input  wire logic         stopFetch,
    output logic              fetchValid,
    output pipePkg::ifIdT     fetchData
);
    import isaPkg::*;

    wordT imem [`PROC_IMEM_DEPTH];
    pcT   pc;
    logic stopped;

    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr] <= imemData;
        end
    end

    // A halt on the wrong side of a taken branch does not stop fetch
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc      <= '0;
            stopped <= 1'b0;
        end else begin
            stopped <= stopped | (stopFetch & ~redirect);
            if (redirect) begin
                pc <= redirectPc;
            end else if (!pcHold) begin
                pc <= pc + 1'b1;
            end
        end
    end

    // Word is captured by the IF/ID register at the end of its PC cycle
    assign fetchValid       = !stopped && !stopFetch;
    assign fetchData.instr  = imem[pc];
    assign fetchData.pcNext = pc + 1'b1;

    redirectNotHeld: assert property (@(posedge clk) disable iff (!rstN)
        !(redirect && pcHold))
        else $error("redirect during PC hold");

endmodule

`default_nettype wire

// File: src/decodeUnit.sv
// Instruction field decode, control generation and register file with bypass
`timescale 1ns/1ps
`default_nettype none
`include "proc_settings.svh"

module decodeUnit (
    input  wire logic           clk,
    input  wire logic           rstN,
    pipeStageIf.stage           ifId,
    input  wire logic           wbWrite,
    input  wire isaPkg::regIdxT wbReg,
    input  wire isaPkg::wordT   wbData,
    output logic                idValid,
    output pipePkg::idExT       idData,
    output logic                stopFetch
);
    import isaPkg::*;
    import pipePkg::*;

    wordT   rf [`PROC_REG_COUNT];
    wordT   instr;
    opcodeT opc;
    regIdxT rs;
    regIdxT rt;
    regIdxT dst;
    ctrlT   ctrl;
    logic   needRs;
    logic   needRt;

    assign instr = ifId.payload.instr;
    assign opc   = opcodeT'(instr[opcLsb +: $bits(opcodeT)]);
    assign rs    = instr[rsLsb +: $bits(regIdxT)];
    assign rt    = instr[rtLsb +: $bits(regIdxT)];

    always_comb begin
        ctrl   = '0;
        needRs = 1'b0;
        needRt = 1'b0;
        dst    = rt;
        case (opc)
            opAdd, opSub, opAnd, opXor: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluOpT'(instr[opcLsb +: 2]);
                needRs        = 1'b1;
                needRt        = 1'b1;
                dst           = instr[rdLsb +: $bits(regIdxT)];
            end
            opAddi: begin
                ctrl.regWrite = 1'b1;
                ctrl.useImm   = 1'b1;
                needRs        = 1'b1;
            end
            opLd: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.useImm   = 1'b1;
                needRs        = 1'b1;
            end
            opSt: begin
                ctrl.memWrite = 1'b1;
                ctrl.useImm   = 1'b1;
                needRs        = 1'b1;
                needRt        = 1'b1;
            end
            opBeqz: begin
                ctrl.isBranch = 1'b1;
                needRs        = 1'b1;
            end
            opHalt: ctrl.isHalt = 1'b1;
            opNop: ;
            default: ctrl.illegal = 1'b1;
        endcase
    end

    // Writes land at the edge, same-cycle reads see the incoming value
    always_ff @(posedge clk) begin
        if (wbWrite) begin
            rf[wbReg] <= wbData;
        end
    end

    always_comb begin
        idData.ctrl     = ctrl;
        idData.opA      = (wbWrite && wbReg == rs) ? wbData : rf[rs];
        idData.opB      = (wbWrite && wbReg == rt) ? wbData : rf[rt];
        idData.imm      = {{(`PROC_WORD_W - immW){instr[immW-1]}}, instr[immW-1:0]};
        idData.brTarget = ifId.payload.pcNext + pcT'(instr[offW-1:0]);
        idData.rs       = rs;
        idData.rt       = rt;
        idData.rd       = dst;
        idData.usesRs   = ifId.valid && needRs;
        idData.usesRt   = ifId.valid && needRt;
    end

    assign idValid   = ifId.valid;
    assign stopFetch = ifId.valid && (ctrl.isHalt || ctrl.illegal);

    wbRegKnown: assert property (@(posedge clk) disable iff (!rstN)
        wbWrite |-> !$isunknown(wbReg))
        else $error("register write with unknown index");

endmodule

`default_nettype wire

// File: src/hazardUnit.sv
// Forwarding selects, load-use stall and branch flush control
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    pipeStageIf.stage           idEx,
    pipeStageIf.stage           exMem,
    pipeStageIf.stage           memWb,
    input  wire isaPkg::regIdxT ifIdRs,
    input  wire isaPkg::regIdxT ifIdRt,
    input  wire logic           ifIdUsesRs,
    input  wire logic           ifIdUsesRt,
    input  wire logic           branchTaken,
    output logic                pcHold,
    output logic [1:0]          fwdA,
    output logic [1:0]          fwdB,
    pipeStageIf.ctrl            ifIdCtrl,
    pipeStageIf.ctrl            idExCtrl
);
    import pipePkg::*;

    logic loadUse;
    logic exMemFwdOk;
    logic memWbFwdOk;

    // Load in execute feeding the instruction in decode
    assign loadUse = idEx.valid && idEx.payload.ctrl.memRead &&
                     ((ifIdUsesRs && idEx.payload.rd == ifIdRs) ||
                      (ifIdUsesRt && idEx.payload.rd == ifIdRt));

    // Load data is not ready in EX/MEM yet
    assign exMemFwdOk = exMem.valid && exMem.payload.ctrl.regWrite &&
                        !exMem.payload.ctrl.memRead;
    assign memWbFwdOk = memWb.valid && memWb.payload.regWrite;

    // Newest producer first
    assign fwdA = (idEx.payload.usesRs && exMemFwdOk && exMem.payload.rd == idEx.payload.rs) ?
                  fwdExMem :
                  (idEx.payload.usesRs && memWbFwdOk && memWb.payload.rd == idEx.payload.rs) ?
                  fwdMemWb : fwdReg;
    assign fwdB = (idEx.payload.usesRt && exMemFwdOk && exMem.payload.rd == idEx.payload.rt) ?
                  fwdExMem :
                  (idEx.payload.usesRt && memWbFwdOk && memWb.payload.rd == idEx.payload.rt) ?
                  fwdMemWb : fwdReg;

    // Taken branch overrides the stall
    assign pcHold         = loadUse && !branchTaken;
    assign ifIdCtrl.hold  = pcHold;
    assign ifIdCtrl.flush = branchTaken;
    assign idExCtrl.hold  = 1'b0;
    assign idExCtrl.flush = loadUse || branchTaken;

endmodule

`default_nettype wire

// File: src/executeUnit.sv
// Operand forwarding muxes, ALU and BEQZ resolution
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
    pipeStageIf.stage         idEx,
    input  wire logic [1:0]   fwdA,
    input  wire logic [1:0]   fwdB,
    input  wire isaPkg::wordT exMemResult,
    input  wire isaPkg::wordT memWbData,
    output logic              exValid,
    output pipePkg::exMemT    exData,
    output logic              branchTaken,
    output isaPkg::pcT        branchTarget
);
    import isaPkg::*;
    import pipePkg::*;

    idExT ix;
    wordT opA;
    wordT opB;
    wordT aluB;
    wordT aluRes;

    assign ix = idEx.payload;

    always_comb begin
        case (fwdA)
            fwdExMem: opA = exMemResult;
            fwdMemWb: opA = memWbData;
            default:  opA = ix.opA;
        endcase
        case (fwdB)
            fwdExMem: opB = exMemResult;
            fwdMemWb: opB = memWbData;
            default:  opB = ix.opB;
        endcase
    end

    // Loads and stores go through here too, address is rs plus imm
    assign aluB = ix.ctrl.useImm ? ix.imm : opB;

    always_comb begin
        case (ix.ctrl.aluOp)
            aluSub:  aluRes = opA - aluB;
            aluAnd:  aluRes = opA & aluB;
            aluXor:  aluRes = opA ^ aluB;
            default: aluRes = opA + aluB;
        endcase
    end

    always_comb begin
        exData.ctrl      = ix.ctrl;
        exData.aluResult = aluRes;
        exData.storeData = opB;
        exData.rd        = ix.rd;
    end

    assign exValid      = idEx.valid;
    assign branchTaken  = idEx.valid && ix.ctrl.isBranch && (opA == '0);
    assign branchTarget = ix.brTarget;

endmodule

`default_nettype wire

// File: src/memUnit.sv
// Data memory access and writeback value selection
`timescale 1ns/1ps
`default_nettype none
`include "proc_settings.svh"

module memUnit (
    input  wire logic      clk,
    pipeStageIf.stage      exMem,
    output logic           memValid,
    output pipePkg::memWbT memData
);
    import isaPkg::*;
    import pipePkg::*;

    localparam int dAddrW = $clog2(`PROC_DMEM_DEPTH);

    wordT              dmem [`PROC_DMEM_DEPTH];
    exMemT             em;
    logic [dAddrW-1:0] addr;

    assign em   = exMem.payload;
    assign addr = em.aluResult[dAddrW-1:0];

    // Store at the edge, a following load sees it next cycle
    always_ff @(posedge clk) begin
        if (exMem.valid && em.ctrl.memWrite) begin
            dmem[addr] <= em.storeData;
        end
    end

    always_comb begin
        memData.wbData   = em.ctrl.memRead ? dmem[addr] : em.aluResult;
        memData.rd       = em.rd;
        memData.regWrite = em.ctrl.regWrite;
        memData.isHalt   = em.ctrl.isHalt;
        memData.illegal  = em.ctrl.illegal;
    end

    assign memValid = exMem.valid;

endmodule

`default_nettype wire

// File: src/proc.sv
// Processor top level with stages, pipeline registers and hazard unit
`timescale 1ns/1ps
`default_nettype none

module proc (
    input  wire logic         clk,
    input  wire logic         rstN,
    input  wire logic         imemWe,
    input  wire isaPkg::pcT   imemAddr,
    input  wire isaPkg::wordT imemData,
    output logic              wbValid,
    output isaPkg::regIdxT    wbReg,
    output isaPkg::wordT      wbData,
    output logic              halted,
    output logic              err
);
    import isaPkg::*;
    import pipePkg::*;

    pipeStageIf #(.payloadT(ifIdT))  ifIdIf ();
    pipeStageIf #(.payloadT(idExT))  idExIf ();
    pipeStageIf #(.payloadT(exMemT)) exMemIf ();
    pipeStageIf #(.payloadT(memWbT)) memWbIf ();

    ifIdT       fetchData;
    idExT       idData;
    exMemT      exData;
    memWbT      memData;
    logic       fetchValid;
    logic       idValid;
    logic       exValid;
    logic       memValid;
    logic       stopFetch;
    logic       pcHold;
    logic       branchTaken;
    pcT         branchTarget;
    logic [1:0] fwdA;
    logic [1:0] fwdB;

    fetchUnit fetch0 (.clk(clk), .rstN(rstN), .imemWe(imemWe), .imemAddr(imemAddr),
        .imemData(imemData), .pcHold(pcHold), .redirect(branchTaken),
        .redirectPc(branchTarget), .stopFetch(stopFetch),
        .fetchValid(fetchValid), .fetchData(fetchData));

    pipeReg #(.payloadT(ifIdT)) ifIdReg0 (.clk(clk), .rstN(rstN),
        .validIn(fetchValid), .dIn(fetchData), .outIf(ifIdIf.regOut));

    decodeUnit decode0 (.clk(clk), .rstN(rstN), .ifId(ifIdIf.stage),
        .wbWrite(wbValid), .wbReg(wbReg), .wbData(wbData),
        .idValid(idValid), .idData(idData), .stopFetch(stopFetch));

    pipeReg #(.payloadT(idExT)) idExReg0 (.clk(clk), .rstN(rstN),
        .validIn(idValid), .dIn(idData), .outIf(idExIf.regOut));

    hazardUnit hazard0 (.idEx(idExIf.stage), .exMem(exMemIf.stage), .memWb(memWbIf.stage),
        .ifIdRs(idData.rs), .ifIdRt(idData.rt), .ifIdUsesRs(idData.usesRs),
        .ifIdUsesRt(idData.usesRt), .branchTaken(branchTaken), .pcHold(pcHold),
        .fwdA(fwdA), .fwdB(fwdB), .ifIdCtrl(ifIdIf.ctrl), .idExCtrl(idExIf.ctrl));

    executeUnit execute0 (.idEx(idExIf.stage), .fwdA(fwdA), .fwdB(fwdB),
        .exMemResult(exMemIf.payload.aluResult), .memWbData(memWbIf.payload.wbData),
        .exValid(exValid), .exData(exData), .branchTaken(branchTaken),
        .branchTarget(branchTarget));

    pipeReg #(.payloadT(exMemT)) exMemReg0 (.clk(clk), .rstN(rstN),
        .validIn(exValid), .dIn(exData), .outIf(exMemIf.regOut));

    memUnit mem0 (.clk(clk), .exMem(exMemIf.stage), .memValid(memValid), .memData(memData));

    pipeReg #(.payloadT(memWbT)) memWbReg0 (.clk(clk), .rstN(rstN),
        .validIn(memValid), .dIn(memData), .outIf(memWbIf.regOut));

    assign exMemIf.hold  = 1'b0;
    assign exMemIf.flush = 1'b0;
    assign memWbIf.flush = 1'b0;
    // Retired HALT or illegal stays in MEM/WB so the status holds until reset
    assign memWbIf.hold  = halted;

    assign wbValid = memWbIf.valid && memWbIf.payload.regWrite;
    assign wbReg   = memWbIf.payload.rd;
    assign wbData  = memWbIf.payload.wbData;
    assign halted  = memWbIf.valid && (memWbIf.payload.isHalt || memWbIf.payload.illegal);
    assign err     = memWbIf.valid && memWbIf.payload.illegal;

endmodule

`default_nettype wire

// File: sim/procTb.sv
// Processor testbench with program loader, instruction-set model, trace monitor and tests
`timescale 1ns/1ps
`default_nettype none
`include "proc_settings.svh"

module procTb;
    import isaPkg::*;

    localparam int haltLimit = 2000;

    logic   clk;
    logic   rstN;
    logic   imemWe;
    pcT     imemAddr;
    wordT   imemData;
    logic   wbValid;
    regIdxT wbReg;
    wordT   wbData;
    logic   halted;
    logic   err;

    wordT   prog [`PROC_IMEM_DEPTH];
    int     progLen;
    regIdxT expRegQ [$];
    wordT   expDataQ [$];
    logic   expErr;
    logic   checking;
    string  testName;
    int     failCount;
    int     testFails;
    int     passTests;
    int     failTests;

    proc i_dut (.clk(clk), .rstN(rstN), .imemWe(imemWe), .imemAddr(imemAddr),
        .imemData(imemData), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
        .halted(halted), .err(err));

    always #5 clk = ~clk;

    // Start values of registers and data memory, shared by DUT and model
    function automatic wordT regFill(int i);
        return wordT'(i * 16'h2351);
    endfunction

    function automatic wordT memFill(int a);
        return wordT'(a * 16'h0107) ^ 16'hA5C3;
    endfunction

    function automatic wordT encR(opcodeT op, regIdxT rd, regIdxT rs, regIdxT rt);
        return {op, rs, rt, rd, 2'b00};
    endfunction

    function automatic wordT encI(opcodeT op, regIdxT rt, regIdxT rs, logic [4:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT encB(regIdxT rs, logic [7:0] off);
        return {opBeqz, rs, off};
    endfunction

    function automatic void clearProgram();
        for (int i = 0; i < `PROC_IMEM_DEPTH; i++) begin
            prog[i] = {opHalt, 11'h000};
        end
        progLen = 0;
    endfunction

    function automatic void emit(wordT w);
        prog[progLen] = w;
        progLen++;
    endfunction

    // Instruction-set model, runs until HALT or an illegal opcode
    function automatic void runIsa();
        wordT       regs [`PROC_REG_COUNT];
        wordT       mem [`PROC_DMEM_DEPTH];
        pcT         pc;
        wordT       ins;
        wordT       imm;
        wordT       addr;
        logic [4:0] opc;
        regIdxT     rs;
        regIdxT     rt;
        regIdxT     rd;
        logic       done;
        for (int i = 0; i < `PROC_REG_COUNT; i++) regs[i] = regFill(i);
        for (int a = 0; a < `PROC_DMEM_DEPTH; a++) mem[a] = memFill(a);
        expRegQ.delete();
        expDataQ.delete();
        expErr = 1'b0;
        pc = '0;
        done = 1'b0;
        for (int steps = 0; steps < 1000 && !done; steps++) begin
            ins  = prog[pc];
            opc  = ins[15:11];
            rs   = ins[10:8];
            rt   = ins[7:5];
            rd   = ins[4:2];
            imm  = {{11{ins[4]}}, ins[4:0]};
            addr = regs[rs] + imm;
            pc   = pc + 1'b1;
            case (opc)
                opAdd, opSub, opAnd, opXor: begin
                    case (opc)
                        opAdd:   regs[rd] = regs[rs] + regs[rt];
                        opSub:   regs[rd] = regs[rs] - regs[rt];
                        opAnd:   regs[rd] = regs[rs] & regs[rt];
                        default: regs[rd] = regs[rs] ^ regs[rt];
                    endcase
                    expRegQ.push_back(rd);
                    expDataQ.push_back(regs[rd]);
                end
                opAddi, opLd: begin
                    regs[rt] = (opc == opLd) ? mem[addr[5:0]] : addr;
                    expRegQ.push_back(rt);
                    expDataQ.push_back(regs[rt]);
                end
                opSt: mem[addr[5:0]] = regs[rt];
                opBeqz: begin
                    if (regs[rs] == '0) pc = pc + pcT'(ins[7:0]);
                end
                opHalt: done = 1'b1;
                opNop: ;
                default: begin
                    expErr = 1'b1;
                    done   = 1'b1;
                end
            endcase
        end
    endfunction

    task automatic checkWrite(regIdxT expReg, wordT expData, regIdxT actReg, wordT actData);
        if (actReg !== expReg) begin
            $display("[FAIL] %s: write register expected %0d actual %0d",
                testName, expReg, actReg);
            failCount++;
        end
        if (actData !== expData) begin
            $display("[FAIL] %s: write data expected %h actual %h", testName, expData, actData);
            failCount++;
        end
    endtask

    task automatic checkStatus(logic expHalted, logic expErrBit, logic actHalted,
                               logic actErr);
        if (actHalted !== expHalted) begin
            $display("[FAIL] %s: halted expected %b actual %b", testName, expHalted, actHalted);
            failCount++;
        end
        if (actErr !== expErrBit) begin
            $display("[FAIL] %s: err expected %b actual %b", testName, expErrBit, actErr);
            failCount++;
        end
    endtask

    // Retire trace against the model queue
    always @(negedge clk) begin : traceMonitor
        regIdxT er;
        wordT   ed;
        if (rstN && checking && wbValid) begin
            if (expRegQ.size() == 0) begin
                $display("%s: register write to r%0d with nothing left to expect",
                    testName, wbReg);
                failCount++;
            end else begin
                er = expRegQ.pop_front();
                ed = expDataQ.pop_front();
                checkWrite(er, ed, wbReg, wbData);
            end
        end
    end

    // Reset, set start state, load program, release
    task automatic startProgram();
        @(posedge clk);
        #1;
        rstN     = 1'b0;
        checking = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        for (int i = 0; i < `PROC_REG_COUNT; i++) i_dut.decode0.rf[i] = regFill(i);
        for (int a = 0; a < `PROC_DMEM_DEPTH; a++) i_dut.mem0.dmem[a] = memFill(a);
        for (int a = 0; a < `PROC_IMEM_DEPTH; a++) begin
            imemWe   = 1'b1;
            imemAddr = pcT'(a);
            imemData = prog[a];
            @(posedge clk);
            #1;
        end
        imemWe = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        runIsa();
        checking = 1'b1;
        rstN     = 1'b1;
    endtask

    task automatic finishProgram();
        int cycles;
        cycles = 0;
        while (!halted && cycles < haltLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("Timeout: %s did not halt within %0d cycles", testName, haltLimit);
            $display("Simulation FAILED");
            $finish;
        end
        // Every older write retires before halted rises
        @(posedge clk);
        if (expRegQ.size() != 0) begin
            $display("%s: %0d expected writes not retired when halted rose",
                testName, expRegQ.size());
            failCount++;
        end
        // Extra cycles so a stray retire would show up
        repeat (10) @(negedge clk);
        checkStatus(1'b1, expErr, halted, err);
        if (failCount == testFails) begin
            $display("[PASS] %s", testName);
            passTests++;
        end else begin
            $display("[FAIL] %s finished with %0d errors", testName, failCount - testFails);
            failTests++;
        end
    endtask

    task automatic beginTest(string name);
        testName  = name;
        testFails = failCount;
    endtask

    // Random ALU ops, half of them reading the previous destination
    function automatic void genAluProgram(int n);
        regIdxT last;
        regIdxT dst;
        regIdxT src;
        clearProgram();
        last = 3'd1;
        for (int k = 0; k < n; k++) begin
            dst = regIdxT'($urandom_range(0, 7));
            src = $urandom_range(0, 1) ? last : regIdxT'($urandom_range(0, 7));
            if ($urandom_range(0, 4) == 0) begin
                emit(encI(opAddi, dst, src, 5'($urandom)));
            end else begin
                emit(encR(opcodeT'(5'd4 + 5'($urandom_range(0, 3))), dst, src,
                    regIdxT'($urandom_range(0, 7))));
            end
            last = dst;
        end
        emit({opHalt, 11'h000});
    endfunction

    // Store, dependent load, immediate use of the loaded value
    function automatic void genMemProgram(int n);
        regIdxT     ra;
        regIdxT     rb;
        regIdxT     rc;
        logic [4:0] imm;
        clearProgram();
        for (int k = 0; k < n; k++) begin
            ra  = regIdxT'($urandom_range(0, 7));
            rb  = regIdxT'($urandom_range(0, 7));
            rc  = regIdxT'($urandom_range(0, 7));
            imm = 5'($urandom);
            emit(encI(opSt, ra, rb, imm));
            emit(encI(opLd, rc, rb, imm));
            emit(encR(opAdd, regIdxT'($urandom_range(0, 7)), rc, ra));
            if ($urandom_range(0, 1)) emit(encI(opAddi, rb, rc, 5'($urandom)));
        end
        emit({opHalt, 11'h000});
    endfunction

    initial begin
        clk       = 1'b0;
        rstN      = 1'b0;
        imemWe    = 1'b0;
        imemAddr  = '0;
        imemData  = '0;
        checking  = 1'b0;
        failCount = 0;
        passTests = 0;
        failTests = 0;
        void'($urandom(4692));

        beginTest("alu forwarding");
        genAluProgram(40);
        startProgram();
        finishProgram();

        beginTest("loads and stores");
        genMemProgram(12);
        startProgram();
        finishProgram();

        beginTest("branches");
        clearProgram();
        emit(encR(opXor, 3'd1, 3'd1, 3'd1));
        emit(encB(3'd1, 8'd2));
        emit(encI(opAddi, 3'd2, 3'd2, 5'd1));
        emit(encI(opAddi, 3'd3, 3'd3, 5'd1));
        emit(encI(opAddi, 3'd4, 3'd1, 5'd5));
        emit(encB(3'd4, 8'd3));
        emit(encI(opAddi, 3'd5, 3'd4, 5'h1b));
        emit(encB(3'd5, 8'd1));
        emit(encI(opAddi, 3'd6, 3'd6, 5'd7));
        emit(encI(opLd, 3'd7, 3'd1, 5'd3));
        emit(encB(3'd7, 8'd1));
        emit(encR(opAdd, 3'd2, 3'd4, 3'd5));
        emit(encR(opSub, 3'd3, 3'd4, 3'd7));
        emit({opHalt, 11'h000});
        startProgram();
        finishProgram();

        beginTest("halt");
        clearProgram();
        emit(encI(opAddi, 3'd1, 3'd0, 5'd3));
        emit(encR(opAdd, 3'd2, 3'd1, 3'd1));
        emit({opHalt, 11'h000});
        emit(encI(opAddi, 3'd3, 3'd3, 5'd1));
        emit(encI(opAddi, 3'd4, 3'd4, 5'd1));
        startProgram();
        finishProgram();

        beginTest("illegal opcode");
        clearProgram();
        emit(encI(opAddi, 3'd1, 3'd2, 5'd9));
        emit(encR(opXor, 3'd2, 3'd1, 3'd3));
        emit({5'b11111, 11'h000});
        emit(encI(opAddi, 3'd3, 3'd3, 5'd1));
        emit(encI(opAddi, 3'd4, 3'd4, 5'd1));
        emit({opHalt, 11'h000});
        startProgram();
        finishProgram();

        beginTest("reset mid-run");
        genAluProgram(30);
        startProgram();
        repeat (12) @(posedge clk);
        #1;
        rstN     = 1'b0;
        checking = 1'b0;
        // Synchronous reset takes effect at the next edge
        @(posedge clk);
        @(negedge clk);
        checkStatus(1'b0, 1'b0, halted, err);
        if (wbValid !== 1'b0) begin
            $display("%s: wbValid still high during reset", testName);
            failCount++;
        end
        startProgram();
        finishProgram();

        $display("Tests passed %0d, failed %0d, errors %0d", passTests, failTests, failCount);
        if (failCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
src/isaPkg.sv
src/pipePkg.sv
src/pipeStageIf.sv
src/pipeReg.sv
src/fetchUnit.sv
src/decodeUnit.sv
src/hazardUnit.sv
src/executeUnit.sv
src/memUnit.sv
src/proc.sv
sim/procTb.sv
